// ==== flist.f ====
verilog/hazard_pkg.sv
verilog/hazard_if.sv
verilog/instr_decode.sv
verilog/hazard_queue_ram.sv
verilog/hazard_ctrl.sv
verilog/issue_stage.sv
verilog/hazard_top.sv
sim/hazard_sva.sv
sim/hazard_tb.sv

// ==== sim/hazard_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_tb;

  localparam int rand_cycles = 400;
  localparam int fill_cycles = 40;
  localparam int clear_cycles = 60;
  localparam int drain_bound = 4;
  localparam int pair_slots = 1 + rand_cycles + fill_cycles + 2 * clear_cycles;
  localparam int cycle_limit = pair_slots * drain_bound + 100;

  logic clock;
  logic reset;
  logic fetch_valid;
  logic [hazard_pkg::xlen-1:0] fetch_pc;
  logic [hazard_pkg::xlen-1:0] fetch_word0;
  logic [hazard_pkg::xlen-1:0] fetch_word1;
  logic clear;
  logic issue_stall;
  logic fetch_stall;
  logic issue_valid0;
  logic [hazard_pkg::xlen-1:0] issue_pc0;
  logic [hazard_pkg::xlen-1:0] issue_word0;
  logic issue_valid1;
  logic [hazard_pkg::xlen-1:0] issue_pc1;
  logic [hazard_pkg::xlen-1:0] issue_word1;

  hazard_pkg::decoded_instr_t model_q[$];
  logic [hazard_pkg::xlen-1:0] next_pc;
  logic strict;
  logic loaded;
  logic held;
  logic saved_valid0;
  logic saved_valid1;
  logic [hazard_pkg::xlen-1:0] saved_pc0;
  logic [hazard_pkg::xlen-1:0] saved_pc1;
  hazard_pkg::instr_word_u saved_word0;
  hazard_pkg::instr_word_u saved_word1;
  int errors;
  int checks;
  int test_errors;
  int test_num;
  int tests_passed;
  int tests_failed;

  hazard_top uut (.*);

  always #20 clock = ~clock;

  function automatic logic [4:0] pick_reg();
    // a narrow register range makes RAW collisions frequent
    if ($urandom_range(3) != 0) begin
      return 5'($urandom_range(3));
    end
    return 5'($urandom_range(31));
  endfunction

  function automatic hazard_pkg::instr_word_u random_word();
    hazard_pkg::instr_word_u w;
    logic [2:0] f3;
    w = '0;
    case ($urandom_range(9))
      0, 1, 2, 3: begin
        w.r.funct3 = 3'($urandom_range(7));
        w.r.rs2 = pick_reg();
        w.r.rs1 = pick_reg();
        w.r.rd = pick_reg();
        w.r.funct7 = ($urandom_range(7) == 0) ? 7'h01 : 7'h00;
        w.r.opcode = hazard_pkg::opc_reg;
      end
      4, 5: begin
        w.i.imm12 = 12'($urandom_range(4095));
        w.i.rs1 = pick_reg();
        w.i.rd = pick_reg();
        w.i.opcode = hazard_pkg::opc_imm;
      end
      6: begin
        w.r.funct7 = 7'h01;
        w.r.funct3 = 3'($urandom_range(7));
        w.r.rs2 = pick_reg();
        w.r.rs1 = pick_reg();
        w.r.rd = pick_reg();
        w.r.opcode = hazard_pkg::opc_reg;
      end
      7: begin
        // csr funct3 is 1 to 3 or 5 to 7
        f3 = 3'($urandom_range(6, 1));
        w.i.funct3 = (f3 >= 3'd4) ? f3 + 3'd1 : f3;
        w.i.imm12 = 12'h300 + 12'($urandom_range(7));
        w.i.rs1 = pick_reg();
        w.i.rd = pick_reg();
        w.i.opcode = hazard_pkg::opc_system;
      end
      8: begin
        w.i.imm12 = 12'h0ff;
        w.i.opcode = hazard_pkg::opc_fence;
      end
      default: begin
        case ($urandom_range(2))
          0: w.i.imm12 = hazard_pkg::sys_ecall;
          1: w.i.imm12 = hazard_pkg::sys_mret;
          default: w.i.imm12 = hazard_pkg::sys_wfi;
        endcase
        w.i.opcode = hazard_pkg::opc_system;
      end
    endcase
    return w;
  endfunction

  // register usage and unit class as the RV32 encoding defines them
  function automatic hazard_pkg::decoded_instr_t classify(
    input logic [hazard_pkg::xlen-1:0] pc,
    input hazard_pkg::instr_word_u w
  );
    hazard_pkg::decoded_instr_t d;
    d = hazard_pkg::init_decoded;
    d.valid = 1'b1;
    d.pc = pc;
    d.word = w;
    d.rd = w.r.rd;
    d.rs1 = w.r.rs1;
    d.rs2 = w.r.rs2;
    if (w.r.opcode == hazard_pkg::opc_reg) begin
      d.wren = 1'b1;
      d.rden1 = 1'b1;
      d.rden2 = 1'b1;
      d.is_muldiv = (w.r.funct7 == 7'h01);
    end else if (w.i.opcode == hazard_pkg::opc_imm) begin
      d.wren = 1'b1;
      d.rden1 = 1'b1;
    end else if (w.i.opcode == hazard_pkg::opc_fence) begin
      d.is_single = 1'b1;
    end else if (w.i.opcode == hazard_pkg::opc_system && w.i.funct3 == 3'd0) begin
      d.is_single = 1'b1;
    end else if (w.i.opcode == hazard_pkg::opc_system) begin
      d.is_csr = 1'b1;
      d.wren = 1'b1;
      d.rden1 = (w.i.funct3 < 3'd4);
    end
    d.wren = d.wren && (w.r.rd != 5'd0);
    return d;
  endfunction

  function automatic logic pair_hazard(
    input hazard_pkg::decoded_instr_t a,
    input hazard_pkg::decoded_instr_t b
  );
    logic raw;
    raw = a.wren && ((b.rden1 && b.rs1 == a.rd) || (b.rden2 && b.rs2 == a.rd));
    return raw || (a.is_muldiv && b.is_muldiv) || (a.is_csr && b.is_csr) ||
      a.is_single || b.is_single;
  endfunction

  task automatic check_bit(input logic actual, input logic expected, input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, actual, expected);
    end
  endtask

  task automatic check_pc(
    input logic [hazard_pkg::xlen-1:0] actual,
    input logic [hazard_pkg::xlen-1:0] expected,
    input string what
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic check_word(
    input hazard_pkg::instr_word_u actual,
    input hazard_pkg::instr_word_u expected,
    input string what
  );
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %h (opcode %b), expected %h (opcode %b)",
               $time, what, actual, actual.r.opcode, expected, expected.r.opcode);
    end
  endtask

  task automatic check_pair(
    input hazard_pkg::decoded_instr_t first,
    input hazard_pkg::decoded_instr_t second,
    input logic dual,
    input logic must_pair
  );
    logic hazard;
    hazard = pair_hazard(first, second);
    checks++;
    if (dual && hazard) begin
      errors++;
      $display("Mismatch at %0t: pc %h and pc %h issued together despite a pairing hazard",
               $time, first.pc, second.pc);
    end else if (!dual && !hazard && must_pair) begin
      errors++;
      $display("Mismatch at %0t: pc %h issued alone although pc %h could pair with it",
               $time, first.pc, second.pc);
    end
  endtask

  always @(posedge clock) begin : monitor
    hazard_pkg::decoded_instr_t first;
    hazard_pkg::decoded_instr_t second;
    if (held) begin
      check_bit(issue_valid0, saved_valid0, "issue_valid0 under issue_stall");
      check_bit(issue_valid1, saved_valid1, "issue_valid1 under issue_stall");
      check_pc(issue_pc0, saved_pc0, "issue_pc0 under issue_stall");
      check_pc(issue_pc1, saved_pc1, "issue_pc1 under issue_stall");
      check_word(issue_word0, saved_word0, "issue_word0 under issue_stall");
      check_word(issue_word1, saved_word1, "issue_word1 under issue_stall");
    end else if (loaded && issue_valid0) begin
      if (model_q.size() == 0) begin
        errors++;
        $display("pc %h issued at %0t although no instruction was outstanding", issue_pc0, $time);
      end else begin
        first = model_q.pop_front();
        check_pc(issue_pc0, first.pc, "issue_pc0");
        check_word(issue_word0, first.word, "issue_word0");
        if (model_q.size() > 0) begin
          check_pair(first, model_q[0], issue_valid1, strict);
        end
        if (issue_valid1 && model_q.size() == 0) begin
          errors++;
          $display("second slot issued at %0t with only one instruction outstanding", $time);
        end else if (issue_valid1) begin
          second = model_q.pop_front();
          check_pc(issue_pc1, second.pc, "issue_pc1");
          check_word(issue_word1, second.word, "issue_word1");
        end
      end
    end else if (loaded) begin
      check_bit(issue_valid1, 1'b0, "issue_valid1 without issue_valid0");
    end
    saved_valid0 = issue_valid0;
    saved_valid1 = issue_valid1;
    saved_pc0 = issue_pc0;
    saved_pc1 = issue_pc1;
    saved_word0 = issue_word0;
    saved_word1 = issue_word1;
    held = reset && !clear && issue_stall;
    loaded = reset && !clear && !issue_stall;
    if (reset && clear) begin
      model_q.delete();
    end
    if (reset && !clear && fetch_valid && !fetch_stall) begin
      model_q.push_back(classify(fetch_pc, fetch_word0));
      model_q.push_back(classify(fetch_pc + 32'd4, fetch_word1));
    end
  end

  initial begin : watchdog
    int n;
    n = 0;
    while (n < cycle_limit) begin
      @(posedge clock);
      n++;
    end
    $display("timeout after %0d cycles with %0d instructions still outstanding",
             n, model_q.size());
    $display("Testbench failed");
    $finish;
  end

  // a pair that was not taken stays on the bus unchanged
  task automatic drive_fetch(input int valid_pct);
    if (fetch_valid && fetch_stall) begin
      return;
    end
    if ($urandom_range(99) < valid_pct) begin
      fetch_valid <= 1'b1;
      fetch_pc <= next_pc;
      fetch_word0 <= random_word();
      fetch_word1 <= random_word();
      next_pc = next_pc + 32'd8;
    end else begin
      fetch_valid <= 1'b0;
    end
  endtask

  task automatic drive_stall(input int stall_pct);
    issue_stall <= ($urandom_range(99) < stall_pct);
  endtask

  task automatic wait_drained();
    @(posedge clock);
    issue_stall <= 1'b0;
    while (fetch_valid && fetch_stall) begin
      @(posedge clock);
    end
    fetch_valid <= 1'b0;
    @(negedge clock);
    while (model_q.size() != 0) begin
      @(negedge clock);
    end
    @(posedge clock);
  endtask

  task automatic begin_test();
    test_num++;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    if (errors == test_errors) begin
      tests_passed++;
      $display("test %0d %s: ok", test_num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", test_num, name, errors - test_errors);
    end
  endtask

  task automatic run_reset_latency();
    begin_test();
    check_bit(issue_valid0, 1'b0, "issue_valid0 after reset");
    check_bit(issue_valid1, 1'b0, "issue_valid1 after reset");
    check_bit(fetch_stall, 1'b0, "fetch_stall after reset");
    @(posedge clock);
    drive_fetch(100);
    @(posedge clock);
    fetch_valid <= 1'b0;
    @(posedge clock);
    check_bit(issue_valid0, 1'b0, "issue_valid0 one cycle after the fetch");
    @(posedge clock);
    check_bit(issue_valid0, 1'b1, "issue_valid0 two cycles after the fetch");
    wait_drained();
    end_test("reset and latency");
  endtask

  task automatic run_random();
    begin_test();
    repeat (rand_cycles) begin
      @(posedge clock);
      drive_fetch(70);
      drive_stall(25);
    end
    wait_drained();
    end_test("random traffic");
  endtask

  task automatic run_backpressure();
    int n;
    begin_test();
    @(posedge clock);
    issue_stall <= 1'b1;
    drive_fetch(100);
    n = 0;
    while (!fetch_stall && n < fill_cycles) begin
      @(posedge clock);
      drive_fetch(100);
      n++;
    end
    if (!fetch_stall) begin
      errors++;
      $display("fetch_stall did not rise within %0d cycles of a stalled issue side", n);
    end
    repeat (8) begin
      @(posedge clock);
      drive_fetch(0);
    end
    check_bit(fetch_stall, 1'b1, "fetch_stall while issue_stall is held");
    issue_stall <= 1'b0;
    strict <= 1'b1;
    wait_drained();
    strict <= 1'b0;
    end_test("back-pressure and drain");
  endtask

  task automatic run_clear();
    begin_test();
    repeat (clear_cycles) begin
      @(posedge clock);
      drive_fetch(80);
      drive_stall(30);
    end
    @(posedge clock);
    clear <= 1'b1;
    drive_fetch(80);
    @(posedge clock);
    clear <= 1'b0;
    drive_fetch(80);
    drive_stall(30);
    @(posedge clock);
    check_bit(issue_valid0, 1'b0, "issue_valid0 after clear");
    repeat (clear_cycles) begin
      @(posedge clock);
      drive_fetch(80);
      drive_stall(30);
    end
    wait_drained();
    end_test("clear flush");
  endtask

  initial begin
    void'($urandom(32'h324c));
    clock = 1'b0;
    reset = 1'b0;
    fetch_valid = 1'b0;
    fetch_pc = '0;
    fetch_word0 = '0;
    fetch_word1 = '0;
    clear = 1'b0;
    issue_stall = 1'b0;
    next_pc = 32'h0000_1000;
    strict = 1'b0;
    held = 1'b0;
    loaded = 1'b0;
    errors = 0;
    checks = 0;
    test_num = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clock);
    reset <= 1'b1;
    run_reset_latency();
    run_random();
    run_backpressure();
    run_clear();
    $display("%0d tests passed, %0d tests failed, %0d checks, %0d errors",
             tests_passed, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/hazard_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_sva (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic issue_stall,
  input logic fetch_stall,
  input logic issue_valid0,
  input logic [hazard_pkg::xlen-1:0] issue_pc0,
  input logic [hazard_pkg::xlen-1:0] issue_word0,
  input logic issue_valid1,
  input logic [hazard_pkg::xlen-1:0] issue_pc1,
  input logic [hazard_pkg::xlen-1:0] issue_word1
);

  // the second slot is only ever filled behind the first
  slot_order: assert property (@(posedge clock) disable iff (!reset)
    issue_valid1 |-> issue_valid0)
    else $error("issue_valid1 is high without issue_valid0");

  stall_hold: assert property (@(posedge clock) disable iff (!reset)
    (issue_stall && !clear) |=> ($stable(issue_valid0) && $stable(issue_valid1) &&
      $stable(issue_pc0) && $stable(issue_word0) &&
      $stable(issue_pc1) && $stable(issue_word1)))
    else $error("issue outputs changed while issue_stall was high");

  reset_state: assert property (@(posedge clock)
    !reset |=> (!fetch_stall && !issue_valid0 && !issue_valid1))
    else $error("fetch_stall or an issue valid is high after reset");

endmodule

bind hazard_top hazard_sva sva_check (
  .clock(clock),
  .reset(reset),
  .clear(clear),
  .issue_stall(issue_stall),
  .fetch_stall(fetch_stall),
  .issue_valid0(issue_valid0),
  .issue_pc0(issue_pc0),
  .issue_word0(issue_word0),
  .issue_valid1(issue_valid1),
  .issue_pc1(issue_pc1),
  .issue_word1(issue_word1)
);

`default_nettype wire

// ==== verilog/hazard_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_top (
  input logic clock,
  input logic reset,
  input logic fetch_valid,
  input logic [hazard_pkg::xlen-1:0] fetch_pc,
  input logic [hazard_pkg::xlen-1:0] fetch_word0,
  input logic [hazard_pkg::xlen-1:0] fetch_word1,
  input logic clear,
  input logic issue_stall,
  output logic fetch_stall,
  output logic issue_valid0,
  output logic [hazard_pkg::xlen-1:0] issue_pc0,
  output logic [hazard_pkg::xlen-1:0] issue_word0,
  output logic issue_valid1,
  output logic [hazard_pkg::xlen-1:0] issue_pc1,
  output logic [hazard_pkg::xlen-1:0] issue_word1
);

  fetch_if fetch_bus ();
  queue_if queue_bus ();
  issue_if issue_bus ();

  instr_decode decode_comp (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .fetch_word0(fetch_word0),
    .fetch_word1(fetch_word1),
    .fetch_stall(fetch_stall),
    .fetch(fetch_bus.source)
  );

  hazard_queue_ram ram_comp (
    .clock(clock),
    .queue(queue_bus.mem)
  );

  hazard_ctrl ctrl_comp (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .issue_stall(issue_stall),
    .fetch(fetch_bus.sink),
    .queue(queue_bus.ctrl),
    .issue(issue_bus.source)
  );

  issue_stage issue_comp (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .issue_stall(issue_stall),
    .issue(issue_bus.sink),
    .issue_valid0(issue_valid0),
    .issue_pc0(issue_pc0),
    .issue_word0(issue_word0),
    .issue_valid1(issue_valid1),
    .issue_pc1(issue_pc1),
    .issue_word1(issue_word1)
  );

endmodule

`default_nettype wire

// ==== verilog/issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic issue_stall,
  issue_if.sink issue,
  output logic issue_valid0,
  output logic [hazard_pkg::xlen-1:0] issue_pc0,
  output logic [hazard_pkg::xlen-1:0] issue_word0,
  output logic issue_valid1,
  output logic [hazard_pkg::xlen-1:0] issue_pc1,
  output logic [hazard_pkg::xlen-1:0] issue_word1
);

  always_ff @(posedge clock) begin
    if (!reset) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
    end else if (clear) begin
      issue_valid0 <= 1'b0;
      issue_valid1 <= 1'b0;
    end else if (!issue_stall) begin
      issue_valid0 <= issue.valid0;
      issue_valid1 <= issue.valid1;
    end
  end

  // the slots keep their contents while downstream is stalled
  always_ff @(posedge clock) begin
    if (!issue_stall) begin
      issue_pc0 <= issue.instr0.pc;
      issue_word0 <= issue.instr0.word;
      issue_pc1 <= issue.instr1.pc;
      issue_word1 <= issue.instr1.word;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/hazard_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic issue_stall,
  fetch_if.sink fetch,
  queue_if.ctrl queue,
  issue_if.source issue
);

  logic [hazard_pkg::ptr_bits-1:0] wid;
  logic [hazard_pkg::ptr_bits-1:0] wid_base;
  logic [hazard_pkg::ptr_bits-1:0] wid_next;
  logic [hazard_pkg::ptr_bits-1:0] row;
  logic [hazard_pkg::ptr_bits-1:0] next_row;
  logic [hazard_pkg::ptr_bits:0] rid;
  logic [hazard_pkg::ptr_bits:0] rid_base;
  logic [hazard_pkg::ptr_bits:0] rid_next;
  logic [hazard_pkg::count_bits-1:0] count;
  logic [hazard_pkg::count_bits-1:0] count_base;
  logic [hazard_pkg::count_bits-1:0] avail;
  logic [hazard_pkg::count_bits-1:0] count_next;
  logic [hazard_pkg::count_bits-1:0] diff;
  logic stall_q;
  logic stall_next;
  logic wen;
  logic hazard;
  hazard_pkg::decoded_instr_t head0;
  hazard_pkg::decoded_instr_t head1;

  // clear acts on this cycle already, so nothing is written or issued
  assign wid_base = clear ? '0 : wid;
  assign rid_base = clear ? '0 : rid;
  assign count_base = clear ? '0 : count;
  assign wen = fetch.valid & ~stall_q & ~clear;

  assign row = rid_base[hazard_pkg::ptr_bits:1];
  assign next_row = row + 1'b1;

  assign queue.wen = wen;
  assign queue.waddr = wid_base;
  assign queue.wdata0 = fetch.instr0;
  assign queue.wdata1 = fetch.instr1;
  // an odd pointer starts in bank 1, so its partner sits in bank 0 of the next row
  assign queue.raddr0 = rid_base[0] ? next_row : row;
  assign queue.raddr1 = row;

  always_comb begin
    if (!rid_base[0]) begin
      if (wid_base == row) begin
        head0 = fetch.instr0;
        head1 = fetch.instr1;
      end else begin
        head0 = queue.rdata0;
        head1 = queue.rdata1;
      end
    end else begin
      head0 = queue.rdata1;
      if (wid_base == next_row) begin
        head1 = fetch.instr0;
      end else begin
        head1 = queue.rdata0;
      end
    end
  end

  always_comb begin
    hazard = head0.is_single | head1.is_single;
    hazard = hazard | (head0.is_muldiv & head1.is_muldiv);
    hazard = hazard | (head0.is_csr & head1.is_csr);
    if (head0.wren) begin
      if (head1.rden1 && head1.rs1 == head0.rd) begin
        hazard = 1'b1;
      end
      if (head1.rden2 && head1.rs2 == head0.rd) begin
        hazard = 1'b1;
      end
    end
  end

  assign avail = wen ? count_base + 2'd2 : count_base;

  always_comb begin
    if (issue_stall || avail == '0) begin
      diff = '0;
    end else if (avail == 'd1 || hazard) begin
      diff = 'd1;
    end else begin
      diff = 'd2;
    end
  end

  assign issue.valid0 = (diff != '0);
  assign issue.valid1 = (diff == 'd2);
  assign issue.instr0 = issue.valid0 ? head0 : hazard_pkg::init_decoded;
  assign issue.instr1 = issue.valid1 ? head1 : hazard_pkg::init_decoded;

  assign count_next = avail - diff;
  assign rid_next = rid_base + diff[hazard_pkg::ptr_bits:0];
  assign wid_next = wen ? wid_base + 1'b1 : wid_base;
  assign stall_next = (count_next > hazard_pkg::stall_level);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wid <= '0;
      rid <= '0;
      count <= '0;
      stall_q <= 1'b0;
    end else begin
      wid <= wid_next;
      rid <= rid_next;
      count <= count_next;
      stall_q <= stall_next;
    end
  end

  assign fetch.stall = stall_q;

endmodule

`default_nettype wire

// ==== verilog/hazard_queue_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazard_queue_ram (
  input logic clock,
  queue_if.mem queue
);

  // bank 0 holds the older slot of each row, bank 1 the younger
  hazard_pkg::decoded_instr_t bank0 [0:hazard_pkg::hazard_depth-1];
  hazard_pkg::decoded_instr_t bank1 [0:hazard_pkg::hazard_depth-1];

  always_ff @(posedge clock) begin
    if (queue.wen) begin
      bank0[queue.waddr] <= queue.wdata0;
      bank1[queue.waddr] <= queue.wdata1;
    end
  end

  assign queue.rdata0 = bank0[queue.raddr0];
  assign queue.rdata1 = bank1[queue.raddr1];

endmodule

`default_nettype wire

// ==== verilog/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic fetch_valid,
  input logic [hazard_pkg::xlen-1:0] fetch_pc,
  input logic [hazard_pkg::xlen-1:0] fetch_word0,
  input logic [hazard_pkg::xlen-1:0] fetch_word1,
  output logic fetch_stall,
  fetch_if.source fetch
);

  hazard_pkg::decoded_instr_t instr0;
  hazard_pkg::decoded_instr_t instr1;

  function automatic hazard_pkg::decoded_instr_t decode(
    input logic [hazard_pkg::xlen-1:0] pc,
    input logic [hazard_pkg::xlen-1:0] raw,
    input logic valid
  );
    hazard_pkg::instr_word_u w;
    hazard_pkg::decoded_instr_t d;
    w = raw;
    d = hazard_pkg::init_decoded;
    d.valid = valid;
    d.pc = pc;
    d.word = w;
    d.rd = w.r.rd;
    d.rs1 = w.r.rs1;
    d.rs2 = w.r.rs2;
    case (w.r.opcode)
      hazard_pkg::opc_reg: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
        d.is_muldiv = (w.r.funct7 == hazard_pkg::funct7_muldiv);
      end
      hazard_pkg::opc_imm, hazard_pkg::opc_load, hazard_pkg::opc_jalr: begin
        d.wren = 1'b1;
        d.rden1 = 1'b1;
      end
      hazard_pkg::opc_lui, hazard_pkg::opc_auipc, hazard_pkg::opc_jal: begin
        d.wren = 1'b1;
      end
      hazard_pkg::opc_store, hazard_pkg::opc_branch: begin
        d.rden1 = 1'b1;
        d.rden2 = 1'b1;
      end
      hazard_pkg::opc_fence: begin
        d.is_single = 1'b1;
      end
      hazard_pkg::opc_system: begin
        if (w.i.funct3 == 3'b000) begin
          // other privileged encodings are not implemented and pair like a nop
          d.is_single = (w.i.imm12 inside {hazard_pkg::sys_ecall, hazard_pkg::sys_ebreak,
                                           hazard_pkg::sys_wfi, hazard_pkg::sys_mret});
        end else begin
          // funct3 bit 2 selects the immediate forms, which read no rs1
          d.is_csr = 1'b1;
          d.wren = 1'b1;
          d.rden1 = ~w.i.funct3[2];
        end
      end
      default: begin
      end
    endcase
    // writes to x0 are dropped, so they cannot create a RAW hazard
    d.wren = d.wren & (d.rd != 5'd0);
    return d;
  endfunction

  always_ff @(posedge clock) begin
    if (!reset) begin
      instr0.valid <= 1'b0;
      instr1.valid <= 1'b0;
    end else if (clear) begin
      instr0.valid <= 1'b0;
      instr1.valid <= 1'b0;
    end else if (!fetch.stall) begin
      instr0 <= decode(fetch_pc, fetch_word0, fetch_valid);
      instr1 <= decode(fetch_pc + 32'd4, fetch_word1, fetch_valid);
    end
  end

  assign fetch.valid = instr0.valid;
  assign fetch.instr0 = instr0;
  assign fetch.instr1 = instr1;
  assign fetch_stall = fetch.stall;

endmodule

`default_nettype wire

// ==== verilog/hazard_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fetch_if;
  logic valid;
  hazard_pkg::decoded_instr_t instr0;
  hazard_pkg::decoded_instr_t instr1;
  logic stall;

  modport source (output valid, output instr0, output instr1, input stall);
  modport sink (input valid, input instr0, input instr1, output stall);
endinterface

interface queue_if;
  logic wen;
  logic [hazard_pkg::ptr_bits-1:0] waddr;
  logic [hazard_pkg::ptr_bits-1:0] raddr0;
  logic [hazard_pkg::ptr_bits-1:0] raddr1;
  hazard_pkg::decoded_instr_t wdata0;
  hazard_pkg::decoded_instr_t wdata1;
  hazard_pkg::decoded_instr_t rdata0;
  hazard_pkg::decoded_instr_t rdata1;

  modport ctrl (
    output wen, output waddr, output raddr0, output raddr1,
    output wdata0, output wdata1,
    input rdata0, input rdata1
  );
  modport mem (
    input wen, input waddr, input raddr0, input raddr1,
    input wdata0, input wdata1,
    output rdata0, output rdata1
  );
endinterface

interface issue_if;
  logic valid0;
  logic valid1;
  hazard_pkg::decoded_instr_t instr0;
  hazard_pkg::decoded_instr_t instr1;

  modport source (output valid0, output valid1, output instr0, output instr1);
  modport sink (input valid0, input valid1, input instr0, input instr1);
endinterface

`default_nettype wire

// ==== verilog/hazard_pkg.sv ====
`default_nettype none

package hazard_pkg;

  localparam int xlen = 32;
  localparam int hazard_depth = 8;
  localparam int ptr_bits = 3;
  localparam int count_bits = 5;

  // leaves room for the pair in the decode register and the one behind it
  localparam int stall_level = 10;

  localparam logic [6:0] opc_load = 7'b0000011;
  localparam logic [6:0] opc_fence = 7'b0001111;
  localparam logic [6:0] opc_imm = 7'b0010011;
  localparam logic [6:0] opc_auipc = 7'b0010111;
  localparam logic [6:0] opc_store = 7'b0100011;
  localparam logic [6:0] opc_reg = 7'b0110011;
  localparam logic [6:0] opc_lui = 7'b0110111;
  localparam logic [6:0] opc_branch = 7'b1100011;
  localparam logic [6:0] opc_jalr = 7'b1100111;
  localparam logic [6:0] opc_jal = 7'b1101111;
  localparam logic [6:0] opc_system = 7'b1110011;

  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  localparam logic [11:0] sys_ecall = 12'h000;
  localparam logic [11:0] sys_ebreak = 12'h001;
  localparam logic [11:0] sys_wfi = 12'h105;
  localparam logic [11:0] sys_mret = 12'h302;

  // the same word read as an R-type or as an I-type instruction
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } i;
  } instr_word_u;

  typedef struct packed {
    logic valid;
    logic [xlen-1:0] pc;
    instr_word_u word;
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic wren;
    logic rden1;
    logic rden2;
    logic is_muldiv;
    logic is_csr;
    // fence and system instructions always issue alone
    logic is_single;
  } decoded_instr_t;

  localparam decoded_instr_t init_decoded = '0;

endpackage

`default_nettype wire
